// File: sources.f
hdl/cache_pkg.sv
hdl/cache_data.sv
hdl/cache_tags.sv
hdl/cache_bank.sv
hdl/mem_arbiter.sv
hdl/main_mem.sv
hdl/cache_top.sv
verification/cache_tb.sv

// File: Makefile
# Verilator build and run of the cache subsystem testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module cache_tb -f sources.f -Mdir obj_dir
	./obj_dir/Vcache_tb | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: verification/cache_tb.sv
//========================================
// Cache subsystem testbench
// Clock, reset, LFSR stimulus, APB tasks,
// shadow memory, read data assertions,
// cycle limit and result line
//========================================
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    // Generous bound for one access, a dirty miss behind the other bank included
    localparam int cycles_per_access = 60;
    localparam int num_steps         = 4 + 3 * 4 + 6 + 2 * 4 + 200;
    localparam int cycle_limit       = cycles_per_access * num_steps + 10;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
        strb_t pstrb;
    } apb_drive_t;

    logic        clk = 1'b0;
    logic        arst_n;
    apb_drive_t  drv [2];
    logic        ready0;
    logic        ready1;
    word_t       rdata0;
    word_t       rdata1;
    word_t       exp0;
    word_t       exp1;
    // Expected memory image, one entry per word address
    word_t       shadow [2**addr_width / 4];
    logic [31:0] lfsr_state = 32'h8f33_d5f2;
    string       test_name  = "none";
    int          errors     = 0;
    int          accesses   = 0;
    int          cycles     = 0;

    always #20 clk = ~clk;

    cache_top cache_top_i (
        .clk        (clk),              .arst_n     (arst_n),
        .p0_psel    (drv[0].psel),      .p0_penable (drv[0].penable),
        .p0_pwrite  (drv[0].pwrite),    .p0_paddr   (drv[0].paddr),
        .p0_pwdata  (drv[0].pwdata),    .p0_pstrb   (drv[0].pstrb),
        .p0_pready  (ready0),           .p0_prdata  (rdata0),
        .p1_psel    (drv[1].psel),      .p1_penable (drv[1].penable),
        .p1_pwrite  (drv[1].pwrite),    .p1_paddr   (drv[1].paddr),
        .p1_pwdata  (drv[1].pwdata),    .p1_pstrb   (drv[1].pstrb),
        .p1_pready  (ready1),           .p1_prdata  (rdata1)
    );

    assign exp0 = shadow[drv[0].paddr[addr_width-1:2]];
    assign exp1 = shadow[drv[1].paddr[addr_width-1:2]];

    // Read data is checked on the edge that completes the transfer
    a_p0_read: assert property (@(posedge clk) disable iff (!arst_n)
        (drv[0].psel && drv[0].penable && !drv[0].pwrite && ready0) |-> (rdata0 == exp0))
        else begin
            errors++;
            $display("** Error %s: port 0 expected %h actual %h",
                     test_name, $sampled(exp0), $sampled(rdata0));
        end

    a_p1_read: assert property (@(posedge clk) disable iff (!arst_n)
        (drv[1].psel && drv[1].penable && !drv[1].pwrite && ready1) |-> (rdata1 == exp1))
        else begin
            errors++;
            $display("** Error %s: port 1 expected %h actual %h",
                     test_name, $sampled(exp1), $sampled(rdata1));
        end

    a_ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        (!ready0 || (drv[0].psel && drv[0].penable)) &&
        (!ready1 || (drv[1].psel && drv[1].penable)))
        else begin
            errors++;
            $display("pready went high while no transfer was in its access phase");
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: no result after %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Collects n fresh bits, one LFSR step per bit
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic port_ready(input int port);
        return (port == 0) ? ready0 : ready1;
    endfunction

    task automatic set_port(input int port, input logic sel, input logic en,
                            input logic wr, input addr_t addr, input word_t data,
                            input strb_t strb);
        drv[port] = '{psel: sel, penable: en, pwrite: wr,
                      paddr: addr, pwdata: data, pstrb: strb};
    endtask

    // Setup phase, then access phase until pready
    task automatic apb_access(input int port, input logic wr, input addr_t addr,
                              input word_t data, input strb_t strb);
        logic done;
        set_port(port, 1'b1, 1'b0, wr, addr, data, strb);
        @(posedge clk);
        #1;
        set_port(port, 1'b1, 1'b1, wr, addr, data, strb);
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            done = port_ready(port);
        end
        // Held through the completing edge
        @(posedge clk);
        #1;
        set_port(port, 1'b0, 1'b0, 1'b0, addr, '0, '0);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[addr[addr_width-1:2]][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        accesses++;
    endtask

    task automatic access_pair(input logic wr0, input addr_t a0, input word_t d0,
                               input strb_t s0, input logic wr1, input addr_t a1,
                               input word_t d1, input strb_t s1);
        fork
            apb_access(0, wr0, a0, d0, s0);
            apb_access(1, wr1, a1, d1, s1);
        join
    endtask

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] d0;
        logic [31:0] d1;
        addr_t       a0;
        addr_t       a1;
        arst_n = 1'b0;
        drv[0] = '0;
        drv[1] = '0;
        for (int i = 0; i < $size(shadow); i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Memory starts cleared, so unwritten words read as zero
        test_name = "reset_state";
        assert (!ready0 && !ready1) else begin
            errors++;
            $display("pready is high right after reset");
        end
        for (int k = 0; k < 4; k++) begin
            rand_bits(6, r0);
            rand_bits(6, r1);
            access_pair(1'b0, {2'b00, r0[5:0], 2'b00}, '0, '0,
                        1'b0, {2'b10, r1[5:0], 2'b00}, '0, '0);
        end

        // Full word first, then a partial write merged over it
        test_name = "strobe_merge";
        for (int k = 0; k < 4; k++) begin
            rand_bits(6, r0);
            rand_bits(6, r1);
            a0 = {2'b00, r0[5:0], 2'b00};
            a1 = {2'b10, r1[5:0], 2'b00};
            rand_bits(32, d0);
            rand_bits(32, d1);
            access_pair(1'b1, a0, d0, 4'hf, 1'b1, a1, d1, 4'hf);
            rand_bits(32, d0);
            rand_bits(32, d1);
            access_pair(1'b1, a0, d0, 4'b0001 << k, 1'b1, a1, d1, ~(4'b0001 << k));
            access_pair(1'b0, a0, '0, '0, 1'b0, a1, '0, '0);
        end

        // Three lines in one set of a two-way bank force a dirty eviction
        test_name = "set_eviction";
        rand_bits(4, r0);
        for (int k = 0; k < 3; k++) begin
            rand_bits(32, d0);
            apb_access(0, 1'b1, {tag_t'(4 + k), r0[1:0], r0[3:2], 2'b00}, d0, 4'hf);
        end
        for (int k = 0; k < 3; k++) begin
            apb_access(0, 1'b0, {tag_t'(4 + k), r0[1:0], r0[3:2], 2'b00}, '0, '0);
        end

        // Tags 7 and 15 are untouched so far, both banks miss together
        test_name = "dual_miss";
        for (int k = 0; k < 4; k++) begin
            rand_bits(32, d0);
            rand_bits(32, d1);
            access_pair(1'b1, {4'd7, 2'(k), 2'(k), 2'b00}, d0, 4'hf,
                        1'b1, {4'd15, 2'(k), 2'(k), 2'b00}, d1, 4'hf);
        end
        for (int k = 0; k < 4; k++) begin
            access_pair(1'b0, {4'd7, 2'(k), 2'(k), 2'b00}, '0, '0,
                        1'b0, {4'd15, 2'(k), 2'(k), 2'b00}, '0, '0);
        end

        // Bit 0 picks the direction, then the word and the strobes
        test_name = "random_mix";
        for (int k = 0; k < 200; k++) begin
            rand_bits(12, r0);
            rand_bits(12, r1);
            rand_bits(32, d0);
            rand_bits(32, d1);
            access_pair(r0[0], {1'b0, r0[7:1], 2'b00}, d0, r0[11:8],
                        r1[0], {1'b1, r1[7:1], 2'b00}, d1, r1[11:8]);
        end

        $display("Run finished: %0d accesses, %0d errors", accesses, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/cache_top.sv
//========================================
// Cache subsystem top level
// Two APB cache banks, arbiter, memory
//========================================
`timescale 1ns/1ps

module cache_top (
    input  logic             clk,
    input  logic             arst_n,
    // Port 0
    input  logic             p0_psel,
    input  logic             p0_penable,
    input  logic             p0_pwrite,
    input  cache_pkg::addr_t p0_paddr,
    input  cache_pkg::word_t p0_pwdata,
    input  cache_pkg::strb_t p0_pstrb,
    output logic             p0_pready,
    output cache_pkg::word_t p0_prdata,
    // Port 1
    input  logic             p1_psel,
    input  logic             p1_penable,
    input  logic             p1_pwrite,
    input  cache_pkg::addr_t p1_paddr,
    input  cache_pkg::word_t p1_pwdata,
    input  cache_pkg::strb_t p1_pstrb,
    output logic             p1_pready,
    output cache_pkg::word_t p1_prdata
);
    import cache_pkg::*;

    mem_req_t req0;
    mem_req_t req1;
    mem_req_t mem_req;
    mem_rsp_t rsp0;
    mem_rsp_t rsp1;
    mem_rsp_t mem_rsp;

    cache_bank bank0_i (
        .clk     (clk),        .arst_n  (arst_n),
        .psel    (p0_psel),    .penable (p0_penable), .pwrite (p0_pwrite),
        .paddr   (p0_paddr),   .pwdata  (p0_pwdata),  .pstrb  (p0_pstrb),
        .pready  (p0_pready),  .prdata  (p0_prdata),
        .mem_req (req0),       .mem_rsp (rsp0)
    );

    cache_bank bank1_i (
        .clk     (clk),        .arst_n  (arst_n),
        .psel    (p1_psel),    .penable (p1_penable), .pwrite (p1_pwrite),
        .paddr   (p1_paddr),   .pwdata  (p1_pwdata),  .pstrb  (p1_pstrb),
        .pready  (p1_pready),  .prdata  (p1_prdata),
        .mem_req (req1),       .mem_rsp (rsp1)
    );

    mem_arbiter arbiter_i (
        .clk     (clk),     .arst_n  (arst_n),
        .req0    (req0),    .req1    (req1),
        .rsp0    (rsp0),    .rsp1    (rsp1),
        .mem_req (mem_req), .mem_rsp (mem_rsp)
    );

    main_mem mem_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .rsp    (mem_rsp)
    );

endmodule

// File: hdl/main_mem.sv
//========================================
// Backing memory, one line per entry
// Response one cycle after the request
//========================================
`timescale 1ns/1ps

module main_mem (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);
    import cache_pkg::*;

    line_t mem_q [2**$bits(line_addr_t)];
    logic  rsp_valid_q;
    line_t rsp_data_q;
    logic  accept;

    // A request still held during its own response is not served twice
    assign accept = req.valid && !rsp_valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
            for (int i = 0; i < 2**$bits(line_addr_t); i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            rsp_valid_q <= accept;
            if (accept && req.write) begin
                mem_q[req.addr] <= req.data;
            end
        end
    end

    // Writes are acknowledged with zero data
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_data_q <= req.write ? '0 : mem_q[req.addr];
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.data  = rsp_data_q;

endmodule

// File: hdl/mem_arbiter.sv
//========================================
// Round-robin memory arbiter
// Grant held until the owner's response
//========================================
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::mem_req_t req0,
    input  cache_pkg::mem_req_t req1,
    output cache_pkg::mem_rsp_t rsp0,
    output cache_pkg::mem_rsp_t rsp1,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);
    logic       busy_q;
    logic       owner_q;
    logic       last_q;
    logic       sel;
    logic [1:0] gnt;

    // Current owner while busy, otherwise the fresh round-robin choice
    always_comb begin
        if (busy_q) begin
            sel = owner_q;
        end else if (req0.valid && req1.valid) begin
            sel = !last_q;
        end else begin
            sel = req1.valid;
        end
    end

    assign gnt[0] = (busy_q || req0.valid || req1.valid) && !sel;
    assign gnt[1] = (busy_q || req0.valid || req1.valid) && sel;

    // Granted request passes straight through
    assign mem_req = sel ? req1 : req0;

    always_comb begin
        rsp0       = mem_rsp;
        rsp0.valid = mem_rsp.valid && gnt[0];
        rsp1       = mem_rsp;
        rsp1.valid = mem_rsp.valid && gnt[1];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (busy_q) begin
            if (mem_rsp.valid) begin
                busy_q <= 1'b0;
                last_q <= owner_q;
            end
        end else if (|gnt) begin
            busy_q  <= 1'b1;
            owner_q <= sel;
        end
    end

    // A response belongs to the single bank holding the grant
    a_rsp_owned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp.valid |-> busy_q)
        else $error("mem_arbiter: memory response while no grant is held");

    a_owner_held: assert property (@(posedge clk) disable iff (!arst_n)
        busy_q |-> (owner_q ? req1.valid : req0.valid))
        else $error("mem_arbiter: granted request dropped before its response");

endmodule

// File: hdl/cache_bank.sv
//========================================
// Cache bank
// APB slave and miss FSM around the
// tag and data stores, line transfers
// to the memory arbiter
//========================================
`timescale 1ns/1ps

module cache_bank (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  cache_pkg::addr_t    paddr,
    input  cache_pkg::word_t    pwdata,
    input  cache_pkg::strb_t    pstrb,
    output logic                pready,
    output cache_pkg::word_t    prdata,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);
    import cache_pkg::*;

    bank_state_t state_q;
    logic        req_valid_q;
    way_sel_t    way_q;
    tag_t        victim_tag_q;

    tag_t        tag;
    set_idx_t    set;
    word_idx_t   word_idx;
    way_sel_t    hit_way;
    way_sel_t    victim_way;
    way_sel_t    data_way;
    logic        hit;
    logic        victim_dirty;
    tag_t        victim_tag;
    logic        tag_update;
    logic        tag_touch;
    logic        data_fill;
    logic        data_write;
    logic        data_read;
    word_t       read_data;
    line_t       dirty_data;

    // APB holds the address for the whole access
    assign tag      = paddr[addr_width-1 -: tag_bits];
    assign set      = paddr[offset_bits +: set_bits];
    assign word_idx = paddr[offset_bits-1:2];
    assign hit      = |hit_way;

    always_comb begin
        tag_update = 1'b0;
        tag_touch  = 1'b0;
        data_fill  = 1'b0;
        data_write = 1'b0;
        data_read  = 1'b0;
        data_way   = way_q;
        case (state_q)
            lookup: begin
                data_way = hit ? hit_way : victim_way;
                if (hit) begin
                    tag_touch  = 1'b1;
                    tag_update = pwrite;
                    data_write = pwrite;
                    data_read  = !pwrite;
                end else begin
                    // Fetch the victim line ahead of the write-back
                    data_read = victim_dirty;
                end
            end
            fill: begin
                tag_update = mem_rsp.valid;
                data_fill  = mem_rsp.valid;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= idle;
            req_valid_q <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (psel && penable) begin
                        state_q <= lookup;
                    end
                end
                lookup: begin
                    if (hit) begin
                        state_q <= respond;
                    end else begin
                        state_q     <= victim_dirty ? write_back : fill;
                        req_valid_q <= 1'b1;
                    end
                end
                write_back: begin
                    // Valid drops for a cycle before the refill request
                    if (mem_rsp.valid) begin
                        state_q     <= fill;
                        req_valid_q <= 1'b0;
                    end
                end
                fill: begin
                    if (mem_rsp.valid) begin
                        state_q     <= lookup;
                        req_valid_q <= 1'b0;
                    end else begin
                        req_valid_q <= 1'b1;
                    end
                end
                respond: state_q <= idle;
                default: state_q <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == lookup) begin
            way_q        <= data_way;
            victim_tag_q <= victim_tag;
        end
    end

    always_comb begin
        mem_req.valid = req_valid_q;
        mem_req.write = (state_q == write_back);
        mem_req.addr  = mem_req.write ? {victim_tag_q, set} : {tag, set};
        mem_req.data  = mem_req.write ? dirty_data : '0;
    end

    assign pready = (state_q == respond);
    assign prdata = read_data;

    cache_tags tags_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .set          (set),
        .tag          (tag),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .update       (tag_update),
        .update_way   (data_way),
        .set_dirty    (state_q == lookup),
        .touch        (tag_touch)
    );

    cache_data data_i (
        .clk        (clk),
        .fill       (data_fill),
        .write      (data_write),
        .read       (data_read),
        .set        (set),
        .word_idx   (word_idx),
        .way        (data_way),
        .fill_data  (mem_rsp.data),
        .write_data (pwdata),
        .write_strb (pstrb),
        .read_data  (read_data),
        .dirty_data (dirty_data)
    );

endmodule

// File: hdl/cache_tags.sv
//========================================
// Cache tag store
// Per-way tag, valid and dirty bits,
// one replacement bit per set
//========================================
`timescale 1ns/1ps

module cache_tags (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::set_idx_t set,
    input  cache_pkg::tag_t     tag,
    output cache_pkg::way_sel_t hit_way,
    output cache_pkg::way_sel_t victim_way,
    output logic                victim_dirty,
    output cache_pkg::tag_t     victim_tag,
    input  logic                update,
    input  cache_pkg::way_sel_t update_way,
    input  logic                set_dirty,
    input  logic                touch
);
    import cache_pkg::*;

    tag_t                               tag_q [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0]  valid_q;
    logic [num_ways-1:0][num_sets-1:0]  dirty_q;
    // Points at the least recently used way of each set
    logic [num_sets-1:0]                repl_q;
    way_sel_t                           valid_at;
    way_sel_t                           dirty_at;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            repl_q  <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (update && update_way[w]) begin
                    valid_q[w][set] <= 1'b1;
                    dirty_q[w][set] <= set_dirty;
                end
            end
            // Accessed way becomes MRU, the other one the next victim
            if (touch) begin
                repl_q[set] <= update_way[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (update && update_way[w]) begin
                tag_q[w][set] <= tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            valid_at[w] = valid_q[w][set];
            dirty_at[w] = dirty_q[w][set];
            hit_way[w]  = valid_q[w][set] && (tag_q[w][set] == tag);
        end
    end

    // Empty ways are filled before anything is evicted
    always_comb begin
        if (!valid_at[0]) begin
            victim_way = 2'b01;
        end else if (!valid_at[1]) begin
            victim_way = 2'b10;
        end else begin
            victim_way = repl_q[set] ? 2'b10 : 2'b01;
        end
    end

    assign victim_dirty = |(victim_way & valid_at & dirty_at);
    assign victim_tag   = victim_way[1] ? tag_q[1][set] : tag_q[0][set];

    a_hit_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit_way))
        else $error("cache_tags: tag hit in more than one way");

endmodule

// File: hdl/cache_data.sv
//========================================
// Cache data store
// Per-way line RAMs with line fill,
// byte-enabled word write, word read
// and victim line output
//========================================
`timescale 1ns/1ps

module cache_data (
    input  logic                clk,
    input  logic                fill,
    input  logic                write,
    input  logic                read,
    input  cache_pkg::set_idx_t  set,
    input  cache_pkg::word_idx_t word_idx,
    input  cache_pkg::way_sel_t  way,
    input  cache_pkg::line_t     fill_data,
    input  cache_pkg::word_t     write_data,
    input  cache_pkg::strb_t     write_strb,
    output cache_pkg::word_t     read_data,
    output cache_pkg::line_t     dirty_data
);
    import cache_pkg::*;

    line_t                      wr_line;
    line_t                      wr_mask;
    line_t                      line_rdata [num_ways];
    word_t                      word_rdata [num_ways];
    logic [$clog2(num_ways)-1:0] way_bin;

    // Fill writes every byte, a word write only the strobed bytes of one word
    always_comb begin
        for (int j = 0; j < words_per_line; j++) begin
            wr_line[j*word_width +: word_width] =
                fill ? fill_data[j*word_width +: word_width] : write_data;
            for (int b = 0; b < word_width / 8; b++) begin
                wr_mask[j*word_width + b*8 +: 8] =
                    {8{fill || (write && write_strb[b] && (word_idx == word_idx_t'(j)))}};
            end
        end
    end

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        line_t mem_q [num_sets];
        line_t rdata_q;

        always_ff @(posedge clk) begin
            if ((fill || write) && way[w]) begin
                mem_q[set] <= (mem_q[set] & ~wr_mask) | (wr_line & wr_mask);
            end
            // Registered read, returns the old line on a same-cycle fill
            if (read || fill) begin
                rdata_q <= mem_q[set];
            end
        end

        assign line_rdata[w] = rdata_q;
        // Word select per way first
        assign word_rdata[w] = rdata_q[word_idx*word_width +: word_width];
    end

    // One-hot to index conversion runs beside the RAM read
    always_comb begin
        way_bin = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (way[i]) begin
                way_bin = i[$clog2(num_ways)-1:0];
            end
        end
    end

    // Way mux last
    assign read_data  = word_rdata[way_bin];
    assign dirty_data = line_rdata[way_bin];

    a_fill_write_excl: assert property (@(posedge clk) !(fill && write))
        else $error("cache_data: fill and write in the same cycle");

endmodule

// File: hdl/cache_pkg.sv
//========================================
// Cache subsystem shared definitions
// Geometry localparams, vector types,
// memory bus structs, controller states
//========================================
package cache_pkg;

    // Address split is tag | set | word | byte
    localparam int addr_width     = 10;
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int num_ways       = 2;
    localparam int num_sets       = 4;
    localparam int offset_bits    = 4;
    localparam int set_bits       = 2;
    localparam int tag_bits       = addr_width - offset_bits - set_bits;

    typedef logic [addr_width-1:0]                 addr_t;
    typedef logic [word_width-1:0]                 word_t;
    typedef logic [word_width/8-1:0]               strb_t;
    typedef logic [words_per_line*word_width-1:0]  line_t;
    typedef logic [addr_width-offset_bits-1:0]     line_addr_t;
    typedef logic [set_bits-1:0]                   set_idx_t;
    typedef logic [tag_bits-1:0]                   tag_t;
    typedef logic [$clog2(words_per_line)-1:0]     word_idx_t;
    // One-hot way select
    typedef logic [num_ways-1:0]                   way_sel_t;

    // Line transfer towards the backing memory
    typedef struct packed {
        logic       valid;
        logic       write;
        line_addr_t addr;
        line_t      data;
    } mem_req_t;

    // Read data or write acknowledge
    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_rsp_t;

    // Bank controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        fill,
        respond
    } bank_state_t;

endpackage
